// ==== datapathPkg.sv ====
/*
  datapath widths and types: data word, register number,
  register count and the program counter index
*/
package datapathPkg;

  // data word carried by every register and read port
  localparam int WordWidth = 32;

  // register numbers address the whole file
  localparam int RegNumWidth = 4;

  // one register per register number
  localparam int NumRegs = 1 << RegNumWidth;

  // top register doubles as the program counter
  localparam int PcReg = NumRegs - 1;

  // plain data word
  typedef logic [WordWidth-1:0] wordT;

  // register number as it appears in Rn, Rm and Rd
  typedef logic [RegNumWidth-1:0] regNumT;

endpackage

// ==== instrFieldsPkg.sv ====
/*
  instruction field positions, control word layout
  and the field types that go with them
*/
package instrFieldsPkg;

  // fetched instruction
  localparam int InstrWidth = 32;
  typedef logic [InstrWidth-1:0] instrT;

  // register fields, each one register number wide
  localparam int RnLsb = 16;
  localparam int RdLsb = 12;
  localparam int RmLsb = 0;

  // set-flags bit
  localparam int SBitPos = 20;

  // shifter operand, low twelve bits
  localparam int ShifterLsb = 0;
  localparam int ShifterWidth = 12;
  typedef logic [ShifterWidth-1:0] shifterT;

  // control word from the control unit
  localparam int CtrlWidth = 13;
  typedef logic [CtrlWidth-1:0] ctrlWordT;

  // sub-field widths
  localparam int OpcodeWidth = 4;
  localparam int MemSizeWidth = 2;
  localparam int AddrModeWidth = 2;

  typedef logic [OpcodeWidth-1:0] opcodeT;
  typedef logic [MemSizeWidth-1:0] memSizeT;
  typedef logic [AddrModeWidth-1:0] addrModeT;

  // control word bit positions, msb down
  localparam int ShiftImmPos = 12;
  localparam int OpcodeLsb = 8;
  localparam int LoadInstPos = 7;
  localparam int RfEnablePos = 6;
  localparam int MemEnablePos = 5;
  localparam int MemWritePos = 4;
  localparam int MemSizeLsb = 2;
  localparam int AddrModeLsb = 0;

endpackage

// ==== regFile.sv ====
/*
  sixteen-entry register file with one write port and three read ports
  register 15 is the program counter with its own increment path
*/
`timescale 1ns/1ns

module regFile
  import datapathPkg::*;
#(
  parameter wordT PcStep = 32'd4,
  parameter wordT ResetPc = '0
)
(
  input  logic   clk,
  input  logic   clr,
  input  logic   wrEn,
  input  logic   pcAdvance,
  input  regNumT wrAddr,
  input  regNumT rdAddrA,
  input  regNumT rdAddrB,
  input  regNumT rdAddrC,
  input  wordT   wrData,
  output wordT   rdDataA,
  output wordT   rdDataB,
  output wordT   rdDataC
);

  // register storage
  wordT regs [NumRegs];

  // one-hot load enable from the write address
  logic [NumRegs-1:0] loadEn;

  // next value for the program counter
  wordT pcNext;

  // write decode
  // nothing selected while wrEn is low
  always_comb
  begin
    loadEn = '0;
    if (wrEn)
    begin
      loadEn[wrAddr] = 1'b1;
    end
  end

  // writeback beats the increment
  always_comb
  begin
    if (loadEn[PcReg])
    begin
      pcNext = wrData;
    end
    else
    begin
      pcNext = regs[PcReg] + PcStep;
    end
  end

  for (genvar g = 0; g < NumRegs; g++)
  begin : genReg
    if (g == PcReg)
    begin : genPc
      // pc loads on a write to it or on an advance
      always_ff @(posedge clk or negedge clr)
      begin
        if (!clr)
        begin
          regs[g] <= ResetPc;
        end
        else if (loadEn[g] || pcAdvance)
        begin
          regs[g] <= pcNext;
        end
      end
    end
    else
    begin : genGp
      // general register, write port only
      always_ff @(posedge clk or negedge clr)
      begin
        if (!clr)
        begin
          regs[g] <= '0;
        end
        else if (loadEn[g])
        begin
          regs[g] <= wrData;
        end
      end
    end
  end

  // read ports
  // combinational, show the stored value, no bypass from the write port
  assign rdDataA = regs[rdAddrA];
  assign rdDataB = regs[rdAddrB];
  assign rdDataC = regs[rdAddrC];

  // write address must be defined when a write is requested
  wrAddrKnown: assert property (
    @(posedge clk) disable iff (!clr)
    wrEn |-> !$isunknown(wrAddr)
  );

  // pc steps by exactly PcStep when no write lands on it
  pcAdvanceStep: assert property (
    @(posedge clk) disable iff (!clr)
    pcAdvance && !(wrEn && wrAddr == PcReg)
    |=> regs[PcReg] == $past(regs[PcReg]) + PcStep
  );

endmodule

// ==== ifIdLatch.sv ====
/*
  IF/ID latch with load enable
  splits the held instruction into register numbers and operand fields
*/
`timescale 1ns/1ns

module ifIdLatch
  import datapathPkg::*;
  import instrFieldsPkg::*;
(
  input  logic    clk,
  input  logic    clr,
  input  logic    ifLoad,
  input  instrT   instr,
  output regNumT  rn,
  output regNumT  rm,
  output regNumT  rd,
  output shifterT shifter,
  output logic    sBit
);

  // held instruction
  instrT instrQ;

  // capture on load, hold otherwise
  always_ff @(posedge clk or negedge clr)
  begin
    if (!clr)
    begin
      instrQ <= '0;
    end
    else if (ifLoad)
    begin
      instrQ <= instr;
    end
  end

  // register numbers
  // Rn and Rm feed read ports A and B, Rd feeds port C and the destination
  assign rn = instrQ[RnLsb +: RegNumWidth];
  assign rm = instrQ[RmLsb +: RegNumWidth];
  assign rd = instrQ[RdLsb +: RegNumWidth];

  // shifter operand overlaps Rm in the low bits
  assign shifter = instrQ[ShifterLsb +: ShifterWidth];

  // set-flags bit
  assign sBit = instrQ[SBitPos];

  // held fields do not move across a cycle without a load
  holdStable: assert property (
    @(posedge clk) disable iff (!clr)
    !ifLoad |=> $stable({rn, rm, rd, shifter, sBit})
  );

endmodule

// ==== idExLatch.sv ====
/*
  ID/EX latch for operands, destination and shifter field
  splits the registered control word into its named fields
*/
`timescale 1ns/1ns

module idExLatch
  import datapathPkg::*;
  import instrFieldsPkg::*;
(
  input  logic     clk,
  input  logic     clr,
  input  logic     sBit,
  input  wordT     opA,
  input  wordT     opB,
  input  wordT     opC,
  input  regNumT   rd,
  input  shifterT  shifter,
  input  ctrlWordT ctrlWord,
  output wordT     exOpA,
  output wordT     exOpB,
  output wordT     exOpC,
  output regNumT   exRd,
  output shifterT  exShifter,
  output logic     exSBit,
  output logic     exShiftImm,
  output logic     exLoadInst,
  output logic     exRfEnable,
  output logic     exMemEnable,
  output logic     exMemWrite,
  output opcodeT   exOpcode,
  output memSizeT  exMemSize,
  output addrModeT exAddrMode
);

  // registered control word
  ctrlWordT ctrlQ;

  // no enable, takes a new set every cycle
  always_ff @(posedge clk or negedge clr)
  begin
    if (!clr)
    begin
      exOpA     <= '0;
      exOpB     <= '0;
      exOpC     <= '0;
      exRd      <= '0;
      exShifter <= '0;
      exSBit    <= 1'b0;
      ctrlQ     <= '0;
    end
    else
    begin
      exOpA     <= opA;
      exOpB     <= opB;
      exOpC     <= opC;
      exRd      <= rd;
      exShifter <= shifter;
      exSBit    <= sBit;
      ctrlQ     <= ctrlWord;
    end
  end

  // control word split
  assign exShiftImm  = ctrlQ[ShiftImmPos];
  assign exOpcode    = ctrlQ[OpcodeLsb +: OpcodeWidth];
  assign exLoadInst  = ctrlQ[LoadInstPos];
  assign exRfEnable  = ctrlQ[RfEnablePos];
  assign exMemEnable = ctrlQ[MemEnablePos];
  assign exMemWrite  = ctrlQ[MemWritePos];

  // access size and addressing mode for the memory stage
  assign exMemSize  = ctrlQ[MemSizeLsb +: MemSizeWidth];
  assign exAddrMode = ctrlQ[AddrModeLsb +: AddrModeWidth];

  // a memory write reaches EX only together with the memory enable
  memWriteNeedsEnable: assert property (
    @(posedge clk) disable iff (!clr)
    !$isunknown(ctrlWord) && ctrlWord[MemWritePos] |=> exMemEnable
  );

endmodule

// ==== decodeStage.sv ====
/*
  decode front end top level
  IF/ID latch, register file and ID/EX latch
*/
`timescale 1ns/1ns

module decodeStage
  import datapathPkg::*;
  import instrFieldsPkg::*;
#(
  parameter wordT PcStep = 32'd4,
  parameter wordT ResetPc = '0
)
(
  input  logic     clk,
  input  logic     clr,
  input  logic     ifLoad,
  input  logic     wrEn,
  input  logic     pcAdvance,
  input  instrT    instr,
  input  regNumT   wrAddr,
  input  wordT     wrData,
  input  ctrlWordT ctrlWord,
  output wordT     exOpA,
  output wordT     exOpB,
  output wordT     exOpC,
  output regNumT   exRd,
  output shifterT  exShifter,
  output logic     exSBit,
  output logic     exShiftImm,
  output logic     exLoadInst,
  output logic     exRfEnable,
  output logic     exMemEnable,
  output logic     exMemWrite,
  output opcodeT   exOpcode,
  output memSizeT  exMemSize,
  output addrModeT exAddrMode
);

  // IF/ID fields
  regNumT  rn;
  regNumT  rm;
  regNumT  rd;
  shifterT shifter;
  logic    sBit;

  // register file read data
  wordT opA;
  wordT opB;
  wordT opC;

  ifIdLatch u_ifId (
    .clk     (clk),
    .clr     (clr),
    .ifLoad  (ifLoad),
    .instr   (instr),
    .rn      (rn),
    .rm      (rm),
    .rd      (rd),
    .shifter (shifter),
    .sBit    (sBit)
  );

  // read ports follow Rn, Rm, Rd in that order
  regFile #(
    .PcStep  (PcStep),
    .ResetPc (ResetPc)
  ) u_regFile (
    .clk       (clk),
    .clr       (clr),
    .wrEn      (wrEn),
    .pcAdvance (pcAdvance),
    .wrAddr    (wrAddr),
    .rdAddrA   (rn),
    .rdAddrB   (rm),
    .rdAddrC   (rd),
    .wrData    (wrData),
    .rdDataA   (opA),
    .rdDataB   (opB),
    .rdDataC   (opC)
  );

  idExLatch u_idEx (
    .clk         (clk),
    .clr         (clr),
    .sBit        (sBit),
    .opA         (opA),
    .opB         (opB),
    .opC         (opC),
    .rd          (rd),
    .shifter     (shifter),
    .ctrlWord    (ctrlWord),
    .exOpA       (exOpA),
    .exOpB       (exOpB),
    .exOpC       (exOpC),
    .exRd        (exRd),
    .exShifter   (exShifter),
    .exSBit      (exSBit),
    .exShiftImm  (exShiftImm),
    .exLoadInst  (exLoadInst),
    .exRfEnable  (exRfEnable),
    .exMemEnable (exMemEnable),
    .exMemWrite  (exMemWrite),
    .exOpcode    (exOpcode),
    .exMemSize   (exMemSize),
    .exAddrMode  (exAddrMode)
  );

endmodule

// ==== tbUtils.svh ====
/*
  testbench helpers: Galois LFSR, bit draws,
  instruction composition and control word cleanup
*/
`ifndef TB_UTILS_SVH
`define TB_UTILS_SVH

// one shift of the 32-bit Galois LFSR, right shifting
function automatic logic [31:0] lfsrStep(input logic [31:0] s);
  if (s[0])
  begin
    return (s >> 1) ^ 32'h80200003;
  end
  return s >> 1;
endfunction

// draw n bits, one LFSR step per bit
// lfsrState lives in the including module
function automatic logic [31:0] randBits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++)
  begin
    lfsrState = lfsrStep(lfsrState);
    v = {v[30:0], lfsrState[0]};
  end
  return v;
endfunction

// instruction from its fields, msb down
// rm sits in the low nibble of the shifter field
function automatic logic [31:0] composeInstr(input logic [10:0] upper, input logic s,
                                             input logic [3:0] rn, input logic [3:0] rd,
                                             input logic [11:0] shifter);
  return {upper, s, rn, rd, shifter};
endfunction

// memWrite (bit 4) only together with memEnable (bit 5)
function automatic logic [12:0] fixMemEnable(input logic [12:0] c);
  logic [12:0] r;
  r = c;
  if (r[4])
  begin
    r[5] = 1'b1;
  end
  return r;
endfunction

`endif

// ==== decodeStageTb.sv ====
/*
  decode front end testbench with clock, reset, stimulus,
  reference model, assertions and timeout
*/
`timescale 1ns/1ns

module decodeStageTb
  import datapathPkg::*;
  import instrFieldsPkg::*;
();

  localparam wordT PcStep = 32'd4;
  localparam wordT ResetPc = 32'd0;

  // all tests together take about 130 cycles
  localparam int TestCycles = 130;
  localparam int MaxCycles = 3 * TestCycles + 10;

  logic     clk;
  logic     clr;
  logic     ifLoad;
  logic     wrEn;
  logic     pcAdvance;
  instrT    instr;
  regNumT   wrAddr;
  wordT     wrData;
  ctrlWordT ctrlWord;

  wordT     exOpA;
  wordT     exOpB;
  wordT     exOpC;
  regNumT   exRd;
  shifterT  exShifter;
  logic     exSBit;
  logic     exShiftImm;
  logic     exLoadInst;
  logic     exRfEnable;
  logic     exMemEnable;
  logic     exMemWrite;
  opcodeT   exOpcode;
  memSizeT  exMemSize;
  addrModeT exAddrMode;

  logic [31:0] lfsrState = 32'h8e28;

  `include "tbUtils.svh"

  // reference model of the register file, IF/ID and expected ex outputs
  wordT     shadow [16];
  instrT    ifq;
  wordT     expOpA;
  wordT     expOpB;
  wordT     expOpC;
  regNumT   expRd;
  shifterT  expShifter;
  logic     expSBit;
  ctrlWordT expCtrl;

  int cycles = 0;

  decodeStage #(
    .PcStep  (PcStep),
    .ResetPc (ResetPc)
  ) u_dut (
    .clk         (clk),
    .clr         (clr),
    .ifLoad      (ifLoad),
    .wrEn        (wrEn),
    .pcAdvance   (pcAdvance),
    .instr       (instr),
    .wrAddr      (wrAddr),
    .wrData      (wrData),
    .ctrlWord    (ctrlWord),
    .exOpA       (exOpA),
    .exOpB       (exOpB),
    .exOpC       (exOpC),
    .exRd        (exRd),
    .exShifter   (exShifter),
    .exSBit      (exSBit),
    .exShiftImm  (exShiftImm),
    .exLoadInst  (exLoadInst),
    .exRfEnable  (exRfEnable),
    .exMemEnable (exMemEnable),
    .exMemWrite  (exMemWrite),
    .exOpcode    (exOpcode),
    .exMemSize   (exMemSize),
    .exAddrMode  (exAddrMode)
  );

  // 8 ns period
  initial
  begin
    clk = 1'b0;
  end

  always #4 clk = ~clk;

  task automatic reportMismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    $display("Fail %s: expected %h, actual %h", name, expected, actual);
    $display("Done: errors found");
    $fatal(1, "check %s failed", name);
  endtask

  // inputs move 1 ns after the edge
  task automatic stepClock();
    @(posedge clk);
    #1;
  endtask

  task automatic applyReset();
    clr = 1'b0;
    ifLoad = 1'b0;
    wrEn = 1'b0;
    pcAdvance = 1'b0;
    ctrlWord = '0;
    repeat (2) @(posedge clk);
    #1;
    clr = 1'b1;
  endtask

  // model steps once per edge
  // operands read the state before the edge without forwarding
  always @(posedge clk or negedge clr)
  begin
    if (!clr)
    begin
      for (int i = 0; i < 16; i++)
      begin
        shadow[i] <= (i == 15) ? ResetPc : '0;
      end
      ifq        <= '0;
      expOpA     <= '0;
      expOpB     <= '0;
      expOpC     <= '0;
      expRd      <= '0;
      expShifter <= '0;
      expSBit    <= 1'b0;
      expCtrl    <= '0;
    end
    else
    begin
      // Rn 19..16, Rm 3..0, Rd 15..12
      expOpA     <= shadow[ifq[19:16]];
      expOpB     <= shadow[ifq[3:0]];
      expOpC     <= shadow[ifq[15:12]];
      expRd      <= ifq[15:12];
      expShifter <= ifq[11:0];
      expSBit    <= ifq[20];
      expCtrl    <= ctrlWord;
      if (ifLoad)
      begin
        ifq <= instr;
      end
      if (wrEn)
      begin
        shadow[wrAddr] <= wrData;
      end
      // a write to the pc wins over the advance
      if (pcAdvance && !(wrEn && wrAddr == 4'd15))
      begin
        shadow[15] <= shadow[15] + PcStep;
      end
    end
  end

  opAMatch: assert property (@(posedge clk) disable iff (!clr) exOpA == expOpA)
    else reportMismatch("opA", $sampled(expOpA), $sampled(exOpA));
  opBMatch: assert property (@(posedge clk) disable iff (!clr) exOpB == expOpB)
    else reportMismatch("opB", $sampled(expOpB), $sampled(exOpB));
  opCMatch: assert property (@(posedge clk) disable iff (!clr) exOpC == expOpC)
    else reportMismatch("opC", $sampled(expOpC), $sampled(exOpC));
  rdMatch: assert property (@(posedge clk) disable iff (!clr) exRd == expRd)
    else reportMismatch("rd", $sampled(expRd), $sampled(exRd));
  shifterMatch: assert property (@(posedge clk) disable iff (!clr) exShifter == expShifter)
    else reportMismatch("shifter", $sampled(expShifter), $sampled(exShifter));
  sBitMatch: assert property (@(posedge clk) disable iff (!clr) exSBit == expSBit)
    else reportMismatch("sBit", $sampled(expSBit), $sampled(exSBit));

  // control fields packed back in layout order from bit 12 down
  ctrlSplit: assert property (@(posedge clk) disable iff (!clr)
    {exShiftImm, exOpcode, exLoadInst, exRfEnable, exMemEnable, exMemWrite,
     exMemSize, exAddrMode} == expCtrl)
    else reportMismatch("ctrlWord", $sampled(expCtrl),
      $sampled({exShiftImm, exOpcode, exLoadInst, exRfEnable, exMemEnable,
                exMemWrite, exMemSize, exAddrMode}));

  // first edge out of reset
  resetCtrlIdle: assert property (@(posedge clk)
    $rose(clr) |-> {exLoadInst, exRfEnable, exMemEnable, exMemWrite} == 4'b0)
    else reportMismatch("resetCtrl", 32'd0,
      $sampled({exLoadInst, exRfEnable, exMemEnable, exMemWrite}));

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles)
    begin
      $display("timeout: run did not finish within %0d cycles", MaxCycles);
      $display("Done: errors found");
      $fatal(1, "timeout");
    end
  end

  initial
  begin
    logic [3:0]  a;
    logic [3:0]  b;
    logic [3:0]  c;
    logic [1:0]  pick;
    logic [11:0] heldShifter;
    wordT        d;
    int          n;
    instr = '0;
    wrAddr = '0;
    wrData = '0;
    applyReset();

    // reset values of every register through all three ports
    for (int i = 0; i < 16; i++)
    begin
      instr = composeInstr(11'd0, 1'b0, 4'(i), 4'(i + 2), {8'd0, 4'(i + 1)});
      ifLoad = 1'b1;
      stepClock();
    end
    ifLoad = 1'b0;
    repeat (2) stepClock();

    // fill every register and read back distinct triples
    for (int i = 0; i < 16; i++)
    begin
      wrEn = 1'b1;
      wrAddr = 4'(i);
      wrData = randBits(32);
      stepClock();
    end
    wrEn = 1'b0;
    for (int k = 0; k < 20; k++)
    begin
      a = 4'(randBits(4));
      instr = composeInstr(11'(randBits(11)), 1'(randBits(1)), a, a ^ 4'hA,
                           {8'(randBits(8)), a ^ 4'h5});
      ifLoad = 1'b1;
      stepClock();
    end
    ifLoad = 1'b0;
    repeat (2) stepClock();

    // random fields and control words with writes and pc steps mixed in
    for (int k = 0; k < 40; k++)
    begin
      instr = randBits(32);
      ctrlWord = fixMemEnable(13'(randBits(13)));
      ifLoad = 1'b1;
      wrEn = 1'(randBits(1));
      wrAddr = 4'(randBits(4));
      wrData = randBits(32);
      pcAdvance = 1'(randBits(1));
      stepClock();
    end

    // pc path from a fresh reset with all ports reading the pc
    applyReset();
    instr = composeInstr(11'd0, 1'b0, 4'd15, 4'd15, 12'h00f);
    ifLoad = 1'b1;
    stepClock();
    ifLoad = 1'b0;
    n = 10;
    pcAdvance = 1'b1;
    repeat (n) stepClock();
    pcAdvance = 1'b0;
    stepClock();
    assert (exOpA == ResetPc + PcStep * n)
      else reportMismatch("pcAdvance", ResetPc + PcStep * n, exOpA);

    // write wins over an advance in the same cycle
    d = randBits(32);
    wrEn = 1'b1;
    wrAddr = 4'd15;
    wrData = d;
    pcAdvance = 1'b1;
    stepClock();
    wrEn = 1'b0;
    pcAdvance = 1'b0;
    stepClock();
    assert (exOpA == d)
      else reportMismatch("pcWrite", d, exOpA);

    // held IF/ID ignores new instr while operands follow writes
    a = 4'(randBits(4));
    b = a ^ 4'h5;
    c = a ^ 4'hA;
    heldShifter = {8'(randBits(8)), b};
    instr = composeInstr(11'(randBits(11)), 1'(randBits(1)), a, c, heldShifter);
    ifLoad = 1'b1;
    stepClock();
    ifLoad = 1'b0;
    for (int k = 0; k < 12; k++)
    begin
      instr = randBits(32);
      pick = 2'(randBits(2));
      wrEn = 1'b1;
      wrAddr = (pick == 2'd0) ? a : ((pick == 2'd1) ? b : c);
      wrData = randBits(32);
      stepClock();
    end
    wrEn = 1'b0;
    repeat (3) stepClock();
    assert (exRd == c)
      else reportMismatch("holdRd", c, exRd);
    assert (exShifter == heldShifter)
      else reportMismatch("holdShifter", heldShifter, exShifter);

    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+.
datapathPkg.sv
instrFieldsPkg.sv
regFile.sv
ifIdLatch.sv
idExLatch.sv
decodeStage.sv
decodeStageTb.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - files:
      - datapathPkg.sv
      - instrFieldsPkg.sv
      - regFile.sv
      - ifIdLatch.sv
      - idExLatch.sv
      - decodeStage.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - decodeStageTb.sv
